// File: dbg_core.f
dbg_core_pkg.sv
dbg_ram.sv
trig_match.sv
ram_wr_ctrl.sv
ram_rd_ctrl.sv
dbg_core.sv
dbg_core_sva.sv
dbg_core_chk.sv
dbg_core_tb.sv

// File: dbg_core.sv
`default_nettype none

module dbg_core (
    input  wire                                  clk,
    input  wire                                  rst_n,

    // **************************************************
    // capture control
    // **************************************************
    input  wire                                  capture_enable,
    input  wire                                  capture_start,
    input  wire                                  capture_done_rd,
    input  wire  [dbg_core_pkg::addr_width-1:0]  pre_trigger_num,
    input  wire  [dbg_core_pkg::data_width-1:0]  trigger_pattern,
    input  wire  [dbg_core_pkg::data_width*dbg_core_pkg::tmode_width-1:0] trigger_mode,
    input  wire                                  trigger_logic,
    input  wire                                  tri_succeed_cnt_overflow_mode,
    input  wire                                  tri_succeed_cnt_clr,

    // probe samples
    input  wire  [dbg_core_pkg::data_width-1:0]  dbg_in_wr_data,
    input  wire                                  dbg_in_wr_vld,

    // **************************************************
    // capture results
    // **************************************************
    output wire                                  tri_succeed,
    output wire  [dbg_core_pkg::data_width-1:0]  tri_data,
    output wire  [dbg_core_pkg::addr_width-1:0]  tri_addr,
    output wire  [dbg_core_pkg::addr_width-1:0]  read_start_addr,
    output wire                                  capture_done,
    output wire  [dbg_core_pkg::cnt_width-1:0]   tri_succeed_cnt,

    // read port
    input  wire                                  capture_rd_en,
    input  wire  [dbg_core_pkg::addr_width-1:0]  capture_rd_addr,
    output wire  [dbg_core_pkg::data_width-1:0]  capture_rd_data,
    output wire                                  capture_rd_vld
);

    wire                                match;
    wire                                trig_arm;
    wire                                trig_sample_vld;

    wire [dbg_core_pkg::addr_width-1:0] ram0_waddr;
    wire [dbg_core_pkg::half_width-1:0] ram0_wdata;
    wire                                ram0_wr_en;
    wire [dbg_core_pkg::addr_width-1:0] ram0_raddr;
    wire                                ram0_rd_en;
    wire [dbg_core_pkg::half_width-1:0] ram0_rdata;

    wire [dbg_core_pkg::addr_width-1:0] ram1_waddr;
    wire [dbg_core_pkg::half_width-1:0] ram1_wdata;
    wire                                ram1_wr_en;
    wire [dbg_core_pkg::addr_width-1:0] ram1_raddr;
    wire                                ram1_rd_en;
    wire [dbg_core_pkg::half_width-1:0] ram1_rdata;

    // controllers share port names with the wires above
    ram_wr_ctrl u_ram_wr_ctrl (.*);

    trig_match u_trig_match (
        .arm        (trig_arm),
        .sample     (dbg_in_wr_data),
        .sample_vld (trig_sample_vld),
        .*
    );

    ram_rd_ctrl u_ram_rd_ctrl (.*);

    // ram0 low half, ram1 high half
    dbg_ram u_ram0 (
        .clk   (clk),
        .wr_en (ram0_wr_en),
        .waddr (ram0_waddr),
        .wdata (ram0_wdata),
        .rd_en (ram0_rd_en),
        .raddr (ram0_raddr),
        .rdata (ram0_rdata)
    );

    dbg_ram u_ram1 (
        .clk   (clk),
        .wr_en (ram1_wr_en),
        .waddr (ram1_waddr),
        .wdata (ram1_wdata),
        .rd_en (ram1_rd_en),
        .raddr (ram1_raddr),
        .rdata (ram1_rdata)
    );

endmodule

`default_nettype wire

// File: dbg_core_chk.sv
`default_nettype none

module dbg_core_chk (
    input wire        clk,
    input wire        rst_n,
    input wire        capture_enable,
    input wire        capture_start,
    input wire        capture_done_rd,
    input wire [3:0]  pre_trigger_num,
    input wire [31:0] trigger_pattern,
    input wire [95:0] trigger_mode,
    input wire        trigger_logic,
    input wire        tri_succeed_cnt_overflow_mode,
    input wire        tri_succeed_cnt_clr,
    input wire [31:0] dbg_in_wr_data,
    input wire        dbg_in_wr_vld,
    input wire        tri_succeed,
    input wire [31:0] tri_data,
    input wire [3:0]  tri_addr,
    input wire [3:0]  read_start_addr,
    input wire        capture_done,
    input wire [3:0]  tri_succeed_cnt,
    input wire        capture_rd_en,
    input wire [3:0]  capture_rd_addr,
    input wire [31:0] capture_rd_data,
    input wire        capture_rd_vld
);

    int          err_cnt = 0;
    int          pend = 0;
    logic [31:0] mem_m [16];
    logic [31:0] rd_q [$];
    logic [31:0] prev_m, data_e, got;
    logic        active, trig, have_prev, done_e, pulse_e, hit;
    int          ptr, stored, left, tri_e, cnt_e;

    // trigger rule per bit reduced over the bits in use
    function automatic logic rule_match(input logic [31:0] s);
        int          used;
        int          hits;
        logic [2:0]  c;
        logic        h;
        used = 0;
        hits = 0;
        for (int i = 0; i < 32; i++) begin
            c = trigger_mode[i*3 +: 3];
            h = 1'b0;
            case (c)
                dbg_core_pkg::tm_equal:  h = s[i] == trigger_pattern[i];
                dbg_core_pkg::tm_differ: h = s[i] != trigger_pattern[i];
                dbg_core_pkg::tm_rise:   h = have_prev && !prev_m[i] && s[i];
                dbg_core_pkg::tm_fall:   h = have_prev && prev_m[i] && !s[i];
                dbg_core_pkg::tm_edge:   h = have_prev && (prev_m[i] != s[i]);
                default:                 h = 1'b0;
            endcase
            if (c >= 1 && c <= 5) begin
                used++;
                if (h) hits++;
            end
        end
        return (used > 0) && (trigger_logic ? hits > 0 : hits == used);
    endfunction

    task automatic check_hex(input string name, input logic [31:0] g, input logic [31:0] e);
        if (g !== e) begin
            err_cnt++;
            $display("error %s got %h expected %h", name, g, e);
        end
    endtask

    // **************************************************
    // model updated on the sampling edge
    // **************************************************
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            active = 0;
            trig = 0;
            done_e = 0;
            pulse_e = 0;
            cnt_e = 0;
            tri_e = 0;
        end else begin
            pulse_e = 0;
            hit = 0;
            if (capture_rd_en)
                rd_q.push_back(mem_m[(tri_e - pre_trigger_num + capture_rd_addr) & 15]);
            if (capture_start && capture_enable) begin
                active = 1;
                trig = 0;
                ptr = 0;
                stored = 0;
                done_e = 0;
                have_prev = 0;
            end else begin
                if (!capture_enable) active = 0;
                if (active && capture_enable && dbg_in_wr_vld) begin
                    hit = !trig && stored >= pre_trigger_num && rule_match(dbg_in_wr_data);
                    mem_m[ptr] = dbg_in_wr_data;
                    if (hit) begin
                        trig = 1;
                        tri_e = ptr;
                        data_e = dbg_in_wr_data;
                        pulse_e = 1;
                        left = 15 - pre_trigger_num;
                    end else if (trig) begin
                        left--;
                    end
                    prev_m = dbg_in_wr_data;
                    have_prev = 1;
                    ptr = (ptr + 1) % 16;
                    stored++;
                end
                if (trig && left == 0) begin
                    active = 0;
                    trig = 0;
                    done_e = 1;
                end else if (capture_done_rd) begin
                    done_e = 0;
                end
            end
            if (tri_succeed_cnt_clr) cnt_e = 0;
            else if (hit && !(cnt_e == 15 && !tri_succeed_cnt_overflow_mode))
                cnt_e = (cnt_e + 1) % 16;
            pend = rd_q.size();
        end
    end

    // compare on the falling edge while outputs are settled
    always @(negedge clk) begin
        if (rst_n) begin
            if (pulse_e && !tri_succeed) begin
                err_cnt++;
                $display("trigger pulse missing after a qualifying sample");
            end else if (!pulse_e && tri_succeed) begin
                err_cnt++;
                $display("unexpected trigger pulse");
            end
            if (pulse_e) begin
                check_hex("tri_addr", tri_addr, tri_e);
                check_hex("tri_data", tri_data, data_e);
                check_hex("read_start_addr", read_start_addr, (tri_e - pre_trigger_num) & 15);
            end
            check_hex("capture_done", capture_done, done_e);
            check_hex("tri_succeed_cnt", tri_succeed_cnt, cnt_e);
            if (capture_rd_vld) begin
                if (rd_q.size() == 0) begin
                    err_cnt++;
                    $display("read data returned without a request");
                end else begin
                    got = rd_q.pop_front();
                    check_hex("capture_rd_data", capture_rd_data, got);
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: dbg_core_pkg.sv
`default_nettype none

package dbg_core_pkg;

    // **************************************************
    // widths and buffer depth
    // **************************************************
    localparam int data_width     = 32;
    localparam int half_width     = data_width / 2;
    localparam int addr_width     = 4;
    localparam int buf_depth      = 1 << addr_width;
    localparam int cnt_width      = 4;
    localparam int ram_read_delay = 1;

    // **************************************************
    // per-bit trigger codes
    // **************************************************
    localparam int tmode_width = 3;

    localparam logic [tmode_width-1:0] tm_ignore = 3'd0;
    localparam logic [tmode_width-1:0] tm_equal  = 3'd1;
    localparam logic [tmode_width-1:0] tm_differ = 3'd2;
    localparam logic [tmode_width-1:0] tm_rise   = 3'd3;
    localparam logic [tmode_width-1:0] tm_fall   = 3'd4;
    // highest real code, anything above acts as ignore
    localparam logic [tmode_width-1:0] tm_edge   = 3'd5;

    // one sample word, whole or as the two ram halves
    typedef union packed {
        logic [data_width-1:0] full;
        struct packed {
            logic [half_width-1:0] hi;
            logic [half_width-1:0] lo;
        } half;
    } dbg_word_u;

endpackage

`default_nettype wire

// File: dbg_core_sva.sv
`default_nettype none

module dbg_core_sva (
    input wire clk,
    input wire rst_n,
    input wire tri_succeed,
    input wire capture_done,
    input wire ram0_wr_en,
    input wire ram1_wr_en,
    input wire capture_rd_en,
    input wire capture_rd_vld
);

    int fail_cnt = 0;

    // trigger pulse is a single cycle
    a_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        tri_succeed |=> !tri_succeed)
        else begin
            $error("tri_succeed held two cycles");
            fail_cnt++;
        end

    // the last sample lands in the cycle done rises and none after it
    a_no_wr: assert property (@(posedge clk) disable iff (!rst_n)
        capture_done && $past(capture_done) |-> !(ram0_wr_en || ram1_wr_en))
        else begin
            $error("ram written while capture_done high");
            fail_cnt++;
        end

    a_rd_lat: assert property (@(posedge clk) disable iff (!rst_n)
        capture_rd_en |-> ##2 capture_rd_vld)
        else begin
            $error("read valid not 2 cycles after enable");
            fail_cnt++;
        end

endmodule

bind dbg_core dbg_core_sva sva0 (.*);

`default_nettype wire

// File: dbg_core_tb.sv
`default_nettype none

module dbg_core_tb;

    logic        clk, rst_n, capture_enable, capture_start, capture_done_rd;
    logic [3:0]  pre_trigger_num, capture_rd_addr;
    logic [31:0] trigger_pattern, dbg_in_wr_data;
    logic [95:0] trigger_mode;
    logic        trigger_logic, tri_succeed_cnt_overflow_mode, tri_succeed_cnt_clr;
    logic        dbg_in_wr_vld, capture_rd_en;
    wire         tri_succeed, capture_done, capture_rd_vld;
    wire  [31:0] tri_data, capture_rd_data;
    wire  [3:0]  tri_addr, read_start_addr, tri_succeed_cnt;

    integer      seed = 32'hc070_7797;
    int          tb_err = 0;

    // capture table
    logic [3:0]  row_pre [8];
    logic [31:0] row_pat [8], row_fval [8];
    logic [95:0] row_mode [8];
    logic        row_logic [8], row_ovf [8], row_clr [8];
    int          row_fidx [8], row_fidx2 [8];

    dbg_core dut0 (.*);
    dbg_core_chk chk0 (.*);

    initial begin
        clk = 0;
        forever #2 clk = ~clk;
    end

    function automatic logic [95:0] modes_on(input logic [31:0] mask, input logic [2:0] code);
        logic [95:0] m;
        m = '0;
        for (int i = 0; i < 32; i++)
            if (mask[i]) m[i*3 +: 3] = code;
        return m;
    endfunction

    task automatic set_row(input int r, input int pre, input logic [31:0] pat,
                           input logic [95:0] mode, input logic lg, input logic ovf,
                           input logic clr, input int f1, input int f2, input logic [31:0] fv);
        row_pre[r] = pre;
        row_pat[r] = pat;
        row_mode[r] = mode;
        row_logic[r] = lg;
        row_ovf[r] = ovf;
        row_clr[r] = clr;
        row_fidx[r] = f1;
        row_fidx2[r] = f2;
        row_fval[r] = fv;
    endtask

    // **************************************************
    // one capture arms, streams, reads back and releases
    // **************************************************
    task automatic run_capture(input int r, input int pass);
        int idx;
        int cyc;
        pre_trigger_num = row_pre[r];
        trigger_pattern = row_pat[r];
        trigger_mode = row_mode[r];
        trigger_logic = row_logic[r];
        tri_succeed_cnt_overflow_mode = row_ovf[r];
        // a capture dropped at once by enable low keeps none of these samples
        capture_enable = 1;
        capture_start = 1;
        @(negedge clk);
        capture_start = 0;
        capture_enable = 0;
        dbg_in_wr_vld = 1;
        repeat (2) begin
            dbg_in_wr_data = $random(seed);
            @(negedge clk);
        end
        dbg_in_wr_vld = 0;
        capture_enable = 1;
        tri_succeed_cnt_clr = row_clr[r] && pass == 2;
        capture_start = 1;
        @(negedge clk);
        capture_start = 0;
        tri_succeed_cnt_clr = 0;
        idx = 0;
        cyc = 0;
        while (!capture_done && cyc < 300) begin
            dbg_in_wr_vld = ($random(seed) & 3) != 0;
            if (dbg_in_wr_vld) begin
                if (idx == row_fidx[r] || idx == row_fidx2[r])
                    dbg_in_wr_data = row_fval[r];
                else if (idx + 1 == row_fidx[r] || idx + 1 == row_fidx2[r])
                    dbg_in_wr_data = ~row_fval[r];
                else
                    dbg_in_wr_data = $random(seed);
                idx++;
            end
            @(negedge clk);
            cyc++;
        end
        if (!capture_done) begin
            tb_err++;
            $display("timeout waiting for capture_done in row %0d", r);
        end
        // samples offered while done is high are never stored
        dbg_in_wr_vld = 1;
        dbg_in_wr_data = $random(seed);
        @(negedge clk);
        dbg_in_wr_vld = 0;
        for (int k = 0; k < 16; k++) begin
            capture_rd_en = 1;
            capture_rd_addr = k;
            @(negedge clk);
        end
        capture_rd_en = 0;
        cyc = 0;
        while (chk0.pend != 0 && cyc < 20) begin
            @(negedge clk);
            cyc++;
        end
        if (chk0.pend != 0) begin
            tb_err++;
            $display("read data did not return in row %0d", r);
        end
        capture_done_rd = 1;
        @(negedge clk);
        capture_done_rd = 0;
    endtask

    initial begin
        rst_n = 0;
        capture_enable = 0;
        capture_start = 0;
        capture_done_rd = 0;
        pre_trigger_num = 0;
        trigger_pattern = 0;
        trigger_mode = 0;
        trigger_logic = 0;
        tri_succeed_cnt_overflow_mode = 0;
        tri_succeed_cnt_clr = 0;
        dbg_in_wr_data = 0;
        dbg_in_wr_vld = 0;
        capture_rd_en = 0;
        capture_rd_addr = 0;
        set_row(0, 4, 32'hdead_beef, modes_on('1, 1), 0, 0, 0, 6, 6, 32'hdead_beef);
        set_row(1, 8, 32'h1234_5678, modes_on('1, 2), 0, 0, 0, 2, 10, 32'hedcb_a987);
        // last stored word is zero so the next capture sees a candidate first edge
        set_row(2, 0, 32'h0, modes_on(32'hf, 1), 1, 0, 0, 0, 15, 32'h0);
        set_row(3, 0, 32'h0, modes_on(32'hff00_0000, 3), 0, 0, 0, 0, 5, 32'hff00_0000);
        set_row(4, 5, 32'h0, modes_on(32'h00ff_0000, 4), 0, 1, 0, 7, 7, 32'h5a00_1234);
        set_row(5, 15, 32'h0, modes_on(32'h0000_ff00, 5), 0, 0, 0, 15, 15, 32'h0000_a500);
        set_row(6, 3, 32'hab00_0000, modes_on(32'hff00_0000, 1) | modes_on(32'h1, 2) |
                modes_on(32'h0000_ff00, 7), 0, 0, 1, 9, 9, 32'hab00_0001);
        set_row(7, 1, 32'h0, modes_on(32'h8000_0000, 5) | modes_on(32'hf, 1), 1, 0, 0, 3, 3,
                32'h8000_0000);
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1;
        // three passes walk the counter to saturation, wrap and clear
        for (int pass = 0; pass < 3; pass++)
            for (int r = 0; r < 8; r++)
                run_capture(r, pass);
        repeat (3) @(negedge clk);
        $display("errors: checker %0d, testbench %0d, assertions %0d",
                 chk0.err_cnt, tb_err, dut0.sva0.fail_cnt);
        if (chk0.err_cnt == 0 && tb_err == 0 && dut0.sva0.fail_cnt == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: dbg_ram.sv
`default_nettype none

module dbg_ram (
    input  wire                                 clk,
    input  wire                                 wr_en,
    input  wire  [dbg_core_pkg::addr_width-1:0] waddr,
    input  wire  [dbg_core_pkg::half_width-1:0] wdata,
    input  wire                                 rd_en,
    input  wire  [dbg_core_pkg::addr_width-1:0] raddr,
    output logic [dbg_core_pkg::half_width-1:0] rdata
);

    logic [dbg_core_pkg::half_width-1:0] mem [dbg_core_pkg::buf_depth];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[waddr] <= wdata;
        end
    end

    // output holds between reads
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rdata <= mem[raddr];
        end
    end

endmodule

`default_nettype wire

// File: ram_rd_ctrl.sv
`default_nettype none

module ram_rd_ctrl (
    input  wire                                 clk,
    input  wire                                 rst_n,
    input  wire  [dbg_core_pkg::addr_width-1:0] read_start_addr,
    input  wire                                 capture_rd_en,
    input  wire  [dbg_core_pkg::addr_width-1:0] capture_rd_addr,
    output logic [dbg_core_pkg::data_width-1:0] capture_rd_data,
    output logic                                capture_rd_vld,
    output logic [dbg_core_pkg::addr_width-1:0] ram0_raddr,
    output logic                                ram0_rd_en,
    input  wire  [dbg_core_pkg::half_width-1:0] ram0_rdata,
    output logic [dbg_core_pkg::addr_width-1:0] ram1_raddr,
    output logic                                ram1_rd_en,
    input  wire  [dbg_core_pkg::half_width-1:0] ram1_rdata
);

    // stage 0 drives the ram, last stage marks data out
    logic [dbg_core_pkg::ram_read_delay:0] rd_vld_pipe;
    logic [dbg_core_pkg::addr_width-1:0]   rd_addr_q;
    dbg_core_pkg::dbg_word_u               rd_word;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_vld_pipe <= '0;
        end else begin
            rd_vld_pipe <= {rd_vld_pipe[dbg_core_pkg::ram_read_delay-1:0], capture_rd_en};
        end
    end

    // time-ordered offset to physical slot, wraps with the buffer
    always_ff @(posedge clk) begin
        if (capture_rd_en) begin
            rd_addr_q <= read_start_addr + capture_rd_addr;
        end
    end

    assign ram0_raddr = rd_addr_q;
    assign ram0_rd_en = rd_vld_pipe[0];
    assign ram1_raddr = rd_addr_q;
    assign ram1_rd_en = rd_vld_pipe[0];

    // **************************************************
    // rejoin the halves
    // **************************************************
    always_comb begin
        rd_word.half.lo = ram0_rdata;
        rd_word.half.hi = ram1_rdata;
    end

    assign capture_rd_data = rd_word.full;
    assign capture_rd_vld  = rd_vld_pipe[dbg_core_pkg::ram_read_delay];

endmodule

`default_nettype wire

// File: ram_wr_ctrl.sv
`default_nettype none

module ram_wr_ctrl (
    input  wire                                 clk,
    input  wire                                 rst_n,
    input  wire                                 capture_enable,
    input  wire                                 capture_start,
    input  wire                                 capture_done_rd,
    input  wire  [dbg_core_pkg::addr_width-1:0] pre_trigger_num,
    input  wire  [dbg_core_pkg::data_width-1:0] dbg_in_wr_data,
    input  wire                                 dbg_in_wr_vld,
    input  wire                                 match,
    output logic                                trig_arm,
    output logic                                trig_sample_vld,
    input  wire                                 tri_succeed_cnt_overflow_mode,
    input  wire                                 tri_succeed_cnt_clr,
    output logic                                tri_succeed,
    output logic [dbg_core_pkg::data_width-1:0] tri_data,
    output logic [dbg_core_pkg::addr_width-1:0] tri_addr,
    output logic [dbg_core_pkg::addr_width-1:0] read_start_addr,
    output logic                                capture_done,
    output logic [dbg_core_pkg::cnt_width-1:0]  tri_succeed_cnt,
    output logic [dbg_core_pkg::addr_width-1:0] ram0_waddr,
    output logic [dbg_core_pkg::half_width-1:0] ram0_wdata,
    output logic                                ram0_wr_en,
    output logic [dbg_core_pkg::addr_width-1:0] ram1_waddr,
    output logic [dbg_core_pkg::half_width-1:0] ram1_wdata,
    output logic                                ram1_wr_en
);

    // idle: !cap_active, search: cap_active && !cap_trig, post: both set
    logic                                cap_active;
    logic                                cap_trig;
    logic [dbg_core_pkg::addr_width-1:0] wr_ptr;
    logic [dbg_core_pkg::addr_width-1:0] stored_cnt;
    logic [dbg_core_pkg::addr_width-1:0] post_left;
    logic [dbg_core_pkg::addr_width-1:0] post_total;
    logic                                start_go;
    logic                                accept;
    logic                                trig_hit;
    logic                                last_sample;
    logic                                wr_en_q;
    logic [dbg_core_pkg::addr_width-1:0] wr_addr_q;
    dbg_core_pkg::dbg_word_u             wr_word_q;

    assign start_go        = capture_start && capture_enable;
    assign accept          = dbg_in_wr_vld && cap_active && capture_enable && !capture_start;
    assign trig_arm        = start_go;
    assign trig_sample_vld = accept;

    // samples still owed after the trigger sample, depth - 1 - pre
    assign post_total  = {dbg_core_pkg::addr_width{1'b1}} - pre_trigger_num;
    assign trig_hit    = accept && !cap_trig && (stored_cnt >= pre_trigger_num) && match;
    assign last_sample = accept && (cap_trig ? (post_left == 1'b1) :
                                               (trig_hit && post_total == '0));

    assign read_start_addr = tri_addr - pre_trigger_num;

    // **************************************************
    // capture FSM and pointers
    // **************************************************
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cap_active   <= 1'b0;
            cap_trig     <= 1'b0;
            wr_ptr       <= '0;
            stored_cnt   <= '0;
            post_left    <= '0;
            capture_done <= 1'b0;
            tri_succeed  <= 1'b0;
            tri_addr     <= '0;
        end else begin
            tri_succeed <= trig_hit;
            if (start_go) begin
                cap_active   <= 1'b1;
                cap_trig     <= 1'b0;
                wr_ptr       <= '0;
                stored_cnt   <= '0;
                capture_done <= 1'b0;
            end else begin
                if (!capture_enable) begin
                    cap_active <= 1'b0;
                end
                if (accept) begin
                    wr_ptr <= wr_ptr + 1'b1;
                    if (stored_cnt != {dbg_core_pkg::addr_width{1'b1}}) begin
                        stored_cnt <= stored_cnt + 1'b1;
                    end
                end
                if (trig_hit) begin
                    cap_trig  <= 1'b1;
                    post_left <= post_total;
                    tri_addr  <= wr_ptr;
                end else if (accept && cap_trig) begin
                    post_left <= post_left - 1'b1;
                end
                if (last_sample) begin
                    cap_active   <= 1'b0;
                    cap_trig     <= 1'b0;
                    capture_done <= 1'b1;
                end else if (capture_done_rd) begin
                    capture_done <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (trig_hit) begin
            tri_data <= dbg_in_wr_data;
        end
    end

    // **************************************************
    // trigger counter
    // **************************************************
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tri_succeed_cnt <= '0;
        end else if (tri_succeed_cnt_clr) begin
            tri_succeed_cnt <= '0;
        end else if (trig_hit) begin
            // saturate unless wrap mode
            if (tri_succeed_cnt != '1 || tri_succeed_cnt_overflow_mode) begin
                tri_succeed_cnt <= tri_succeed_cnt + 1'b1;
            end
        end
    end

    // ram write one cycle after accept
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_en_q <= 1'b0;
        end else begin
            wr_en_q <= accept;
        end
    end

    always_ff @(posedge clk) begin
        wr_addr_q      <= wr_ptr;
        wr_word_q.full <= dbg_in_wr_data;
    end

    assign ram0_wr_en = wr_en_q;
    assign ram0_waddr = wr_addr_q;
    assign ram0_wdata = wr_word_q.half.lo;
    assign ram1_wr_en = wr_en_q;
    assign ram1_waddr = wr_addr_q;
    assign ram1_wdata = wr_word_q.half.hi;

endmodule

`default_nettype wire

// File: trig_match.sv
`default_nettype none

module trig_match (
    input  wire                                   clk,
    input  wire                                   rst_n,
    input  wire                                   arm,
    input  wire  [dbg_core_pkg::data_width-1:0]   sample,
    input  wire                                   sample_vld,
    input  wire  [dbg_core_pkg::data_width-1:0]   trigger_pattern,
    input  wire  [dbg_core_pkg::data_width*dbg_core_pkg::tmode_width-1:0] trigger_mode,
    input  wire                                   trigger_logic,
    output logic                                  match
);

    logic [dbg_core_pkg::data_width-1:0]  prev_sample;
    logic                                 prev_vld;
    logic [dbg_core_pkg::tmode_width-1:0] bit_mode [dbg_core_pkg::data_width];
    logic [dbg_core_pkg::data_width-1:0]  bit_used;
    logic [dbg_core_pkg::data_width-1:0]  bit_hit;

    // **************************************************
    // edge history
    // **************************************************
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            prev_vld <= 1'b0;
        end else if (arm) begin
            // first sample of a new capture has no edge
            prev_vld <= 1'b0;
        end else if (sample_vld) begin
            prev_vld <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (sample_vld) begin
            prev_sample <= sample;
        end
    end

    // **************************************************
    // per-bit evaluation
    // **************************************************
    always_comb begin
        for (int i = 0; i < dbg_core_pkg::data_width; i++) begin
            bit_mode[i] = trigger_mode[i*dbg_core_pkg::tmode_width +: dbg_core_pkg::tmode_width];
            bit_used[i] = (bit_mode[i] != dbg_core_pkg::tm_ignore) &&
                          (bit_mode[i] <= dbg_core_pkg::tm_edge);
            case (bit_mode[i])
                dbg_core_pkg::tm_equal:  bit_hit[i] = sample[i] == trigger_pattern[i];
                dbg_core_pkg::tm_differ: bit_hit[i] = sample[i] != trigger_pattern[i];
                dbg_core_pkg::tm_rise:   bit_hit[i] = prev_vld && !prev_sample[i] && sample[i];
                dbg_core_pkg::tm_fall:   bit_hit[i] = prev_vld && prev_sample[i] && !sample[i];
                dbg_core_pkg::tm_edge:   bit_hit[i] = prev_vld && (prev_sample[i] != sample[i]);
                default:                 bit_hit[i] = 1'b0;
            endcase
        end
    end

    // and over used bits, or any used bit; nothing used never matches
    assign match = sample_vld && (|bit_used) &&
                   (trigger_logic ? |bit_hit : &(bit_hit | ~bit_used));

endmodule

`default_nettype wire
